// File: rtl/rvIsaPkg.sv
package rvIsaPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIndex_t;
  typedef logic [3:0]  aluOp_t;

  // alu operation codes with add at zero so a cleared bundle is harmless
  localparam aluOp_t aluAdd  = 4'd0;
  localparam aluOp_t aluSub  = 4'd1;
  localparam aluOp_t aluAnd  = 4'd2;
  localparam aluOp_t aluOr   = 4'd3;
  localparam aluOp_t aluXor  = 4'd4;
  localparam aluOp_t aluSlt  = 4'd5;
  localparam aluOp_t aluSltu = 4'd6;

  // major opcodes
  localparam logic [6:0] opOp    = 7'b0110011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  // lw and sw
  localparam logic [2:0] f3Word   = 3'b010;

  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Sub  = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t nopInstruction = 32'h0000_0013;

  localparam int dataMemWords = 64;

endpackage

// File: rtl/rvPipePkg.sv
package rvPipePkg;
  import rvIsaPkg::*;

  typedef struct packed {
    logic   aluSrc;
    logic   memRead;
    logic   memWrite;
    logic   memToReg;
    logic   regWrite;
    aluOp_t aluOp;
  } ctrl_t;

  // a bubble does nothing in any later stage
  localparam ctrl_t bubbleCtrl = '0;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     rs1Value;
    word_t     rs2Value;
    regIndex_t rs1;
    regIndex_t rs2;
    regIndex_t rd;
    word_t     imm;
  } decodeToExec_t;

  // only the memory and write-back fields of ctrl matter from here on
  typedef struct packed {
    ctrl_t     ctrl;
    word_t     aluResult;
    word_t     storeData;
    regIndex_t rd;
  } execToMem_t;

  typedef struct packed {
    regIndex_t rd;
    word_t     value;
  } retire_t;

endpackage

// File: rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
  import rvIsaPkg::*;
(
  input  logic  clk,
  input  logic  arstN,
  input  logic  stall,
  input  word_t instruction,
  output word_t pc,
  output word_t decodeInstruction
);

  // pc and the fetch-to-decode register move together
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc                <= '0;
      decodeInstruction <= nopInstruction;
    end else if (!stall) begin
      pc                <= pc + 32'd4;
      decodeInstruction <= instruction;
    end
  end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile
  import rvIsaPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  regIndex_t readIndexA,
  input  regIndex_t readIndexB,
  output word_t     readValueA,
  output word_t     readValueB,
  input  logic      writeEnable,
  input  regIndex_t writeIndex,
  input  word_t     writeValue
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeIndex != '0) begin
      regs[writeIndex] <= writeValue;
    end
  end

  // the value being written this cycle is visible to decode right away
  assign readValueA = (readIndexA == '0) ? '0 :
                      (writeEnable && writeIndex == readIndexA) ? writeValue : regs[readIndexA];
  assign readValueB = (readIndexB == '0) ? '0 :
                      (writeEnable && writeIndex == readIndexB) ? writeValue : regs[readIndexB];

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
  import rvIsaPkg::*;
  import rvPipePkg::*;
(
  input  logic          clk,
  input  logic          arstN,
  input  word_t         decodeInstruction,
  input  word_t         readValueA,
  input  word_t         readValueB,
  output regIndex_t     readIndexA,
  output regIndex_t     readIndexB,
  input  regIndex_t     execRd,
  input  logic          execMemRead,
  output logic          stall,
  output decodeToExec_t toExec
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  regIndex_t     rd;
  logic          usesRs2;
  ctrl_t         ctrl;
  word_t         imm;
  decodeToExec_t nextToExec;

  assign opcode     = decodeInstruction[6:0];
  assign rd         = decodeInstruction[11:7];
  assign funct3     = decodeInstruction[14:12];
  assign readIndexA = decodeInstruction[19:15];
  assign readIndexB = decodeInstruction[24:20];
  assign funct7     = decodeInstruction[31:25];

  always_comb begin
    ctrl = bubbleCtrl;
    case (opcode)
      opOp: begin
        if (funct7 == funct7Base || (funct7 == funct7Sub && funct3 == f3AddSub)) begin
          ctrl.regWrite = 1'b1;
          case (funct3)
            f3AddSub: ctrl.aluOp = (funct7 == funct7Sub) ? aluSub : aluAdd;
            f3Slt:    ctrl.aluOp = aluSlt;
            f3Sltu:   ctrl.aluOp = aluSltu;
            f3Xor:    ctrl.aluOp = aluXor;
            f3Or:     ctrl.aluOp = aluOr;
            f3And:    ctrl.aluOp = aluAnd;
            // shifts are not supported
            default:  ctrl.regWrite = 1'b0;
          endcase
        end
      end
      opOpImm: begin
        if (funct3 == f3AddSub) begin
          ctrl.aluSrc   = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      opLoad: begin
        if (funct3 == f3Word) begin
          ctrl.aluSrc   = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      opStore: begin
        if (funct3 == f3Word) begin
          ctrl.aluSrc   = 1'b1;
          ctrl.memWrite = 1'b1;
        end
      end
      default: ;
    endcase
    // writes to x0 are dropped here once and for all
    if (rd == '0) begin
      ctrl.regWrite = 1'b0;
    end
  end

  // store offsets are split across the word
  assign imm = (opcode == opStore) ?
               {{20{decodeInstruction[31]}}, decodeInstruction[31:25], decodeInstruction[11:7]} :
               {{20{decodeInstruction[31]}}, decodeInstruction[31:20]};

  // load-use hazard
  assign usesRs2 = (opcode == opOp) || (opcode == opStore);
  assign stall   = execMemRead && execRd != '0 &&
                   (execRd == readIndexA || (usesRs2 && execRd == readIndexB));

  always_comb begin
    nextToExec.ctrl     = stall ? bubbleCtrl : ctrl;
    nextToExec.rs1Value = readValueA;
    nextToExec.rs2Value = readValueB;
    nextToExec.rs1      = readIndexA;
    nextToExec.rs2      = readIndexB;
    nextToExec.rd       = rd;
    nextToExec.imm      = imm;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toExec <= '0;
    end else begin
      toExec <= nextToExec;
    end
  end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage
  import rvIsaPkg::*;
  import rvPipePkg::*;
(
  input  logic          clk,
  input  logic          arstN,
  input  decodeToExec_t fromDecode,
  input  logic          wbRegWrite,
  input  regIndex_t     wbRd,
  input  word_t         wbValue,
  output regIndex_t     execRd,
  output logic          execMemRead,
  output execToMem_t    toMem
);

  word_t      operandA;
  word_t      forwardedB;
  word_t      operandB;
  word_t      aluResult;
  execToMem_t nextToMem;

  // newest producer wins so the memory stage goes before write-back
  function automatic word_t forwardOperand(
    regIndex_t src,
    word_t     regValue,
    logic      memRegWrite,
    regIndex_t memRd,
    word_t     memValue,
    logic      lateRegWrite,
    regIndex_t lateRd,
    word_t     lateValue
  );
    word_t picked;
    picked = regValue;
    if (memRegWrite && memRd == src) begin
      picked = memValue;
    end else if (lateRegWrite && lateRd == src) begin
      picked = lateValue;
    end
    return picked;
  endfunction

  assign operandA   = forwardOperand(fromDecode.rs1, fromDecode.rs1Value, toMem.ctrl.regWrite,
                                     toMem.rd, toMem.aluResult, wbRegWrite, wbRd, wbValue);
  assign forwardedB = forwardOperand(fromDecode.rs2, fromDecode.rs2Value, toMem.ctrl.regWrite,
                                     toMem.rd, toMem.aluResult, wbRegWrite, wbRd, wbValue);
  assign operandB   = fromDecode.ctrl.aluSrc ? fromDecode.imm : forwardedB;

  always_comb begin
    case (fromDecode.ctrl.aluOp)
      aluAdd:  aluResult = operandA + operandB;
      aluSub:  aluResult = operandA - operandB;
      aluAnd:  aluResult = operandA & operandB;
      aluOr:   aluResult = operandA | operandB;
      aluXor:  aluResult = operandA ^ operandB;
      aluSlt:  aluResult = {31'd0, $signed(operandA) < $signed(operandB)};
      aluSltu: aluResult = {31'd0, operandA < operandB};
      default: aluResult = '0;
    endcase
  end

  always_comb begin
    nextToMem.ctrl      = fromDecode.ctrl;
    nextToMem.aluResult = aluResult;
    nextToMem.storeData = forwardedB;
    nextToMem.rd        = fromDecode.rd;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toMem <= '0;
    end else begin
      toMem <= nextToMem;
    end
  end

  // seen by decode for load-use detection
  assign execRd      = fromDecode.rd;
  assign execMemRead = fromDecode.ctrl.memRead;

  assertMemNotRType: assert property (
    @(posedge clk) disable iff (!arstN)
    (fromDecode.ctrl.memRead || fromDecode.ctrl.memWrite) |->
      (fromDecode.ctrl.aluSrc && !(fromDecode.ctrl.memRead && fromDecode.ctrl.memWrite))
  );

endmodule

// File: rtl/resultStage.sv
`timescale 1ns/1ps

module resultStage
  import rvIsaPkg::*;
  import rvPipePkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  execToMem_t fromExec,
  output logic       wbRegWrite,
  output regIndex_t  wbRd,
  output word_t      wbValue,
  output logic       retireValid,
  output retire_t    retire
);

  word_t                             dataMem [dataMemWords];
  logic [$clog2(dataMemWords)-1:0]   memIndex;
  word_t                             memValue;

  // word address without the byte offset
  assign memIndex = fromExec.aluResult[$clog2(dataMemWords)+1:2];
  assign memValue = fromExec.ctrl.memToReg ? dataMem[memIndex] : fromExec.aluResult;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < dataMemWords; i++) begin
        dataMem[i] <= '0;
      end
    end else if (fromExec.ctrl.memWrite) begin
      dataMem[memIndex] <= fromExec.storeData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbRegWrite <= 1'b0;
    end else begin
      wbRegWrite <= fromExec.ctrl.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbRd    <= fromExec.rd;
    wbValue <= memValue;
  end

  assign retireValid = wbRegWrite;
  assign retire      = '{rd: wbRd, value: wbValue};

  assertAddrInRange: assert property (
    @(posedge clk) disable iff (!arstN)
    (fromExec.ctrl.memRead || fromExec.ctrl.memWrite) |->
      (fromExec.aluResult < dataMemWords * 4 && fromExec.aluResult[1:0] == 2'b00)
  );

endmodule

// File: rtl/rvPipeline.sv
`timescale 1ns/1ps

module rvPipeline
  import rvIsaPkg::*;
  import rvPipePkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  output word_t   pc,
  input  word_t   instruction,
  output logic    retireValid,
  output retire_t retire
);

  word_t         decodeInstruction;
  regIndex_t     readIndexA;
  regIndex_t     readIndexB;
  word_t         readValueA;
  word_t         readValueB;
  regIndex_t     execRd;
  logic          execMemRead;
  logic          stall;
  decodeToExec_t toExec;
  execToMem_t    toMem;
  logic          wbRegWrite;
  regIndex_t     wbRd;
  word_t         wbValue;

  fetchUnit fetch (
    .clk(clk),
    .arstN(arstN),
    .stall(stall),
    .instruction(instruction),
    .pc(pc),
    .decodeInstruction(decodeInstruction)
  );

  registerFile regFile (
    .clk(clk),
    .arstN(arstN),
    .readIndexA(readIndexA),
    .readIndexB(readIndexB),
    .readValueA(readValueA),
    .readValueB(readValueB),
    .writeEnable(wbRegWrite),
    .writeIndex(wbRd),
    .writeValue(wbValue)
  );

  decodeStage decode (
    .clk(clk),
    .arstN(arstN),
    .decodeInstruction(decodeInstruction),
    .readValueA(readValueA),
    .readValueB(readValueB),
    .readIndexA(readIndexA),
    .readIndexB(readIndexB),
    .execRd(execRd),
    .execMemRead(execMemRead),
    .stall(stall),
    .toExec(toExec)
  );

  executeStage execute (
    .clk(clk),
    .arstN(arstN),
    .fromDecode(toExec),
    .wbRegWrite(wbRegWrite),
    .wbRd(wbRd),
    .wbValue(wbValue),
    .execRd(execRd),
    .execMemRead(execMemRead),
    .toMem(toMem)
  );

  // memory access and write-back register
  resultStage result (
    .clk(clk),
    .arstN(arstN),
    .fromExec(toMem),
    .wbRegWrite(wbRegWrite),
    .wbRd(wbRd),
    .wbValue(wbValue),
    .retireValid(retireValid),
    .retire(retire)
  );

endmodule

// File: test/rvIsaModel.svh
`ifndef rvIsaModelSvh
`define rvIsaModelSvh

// alu kind 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sltu
function automatic word_t encAlu(int kind, int rd, int rs1, int rs2);
  logic [2:0] f3;
  logic [6:0] f7;
  f7 = (kind == 1) ? funct7Sub : funct7Base;
  case (kind)
    0, 1: f3 = f3AddSub;
    2: f3 = f3And;
    3: f3 = f3Or;
    4: f3 = f3Xor;
    5: f3 = f3Slt;
    default: f3 = f3Sltu;
  endcase
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
endfunction

function automatic word_t encAddi(int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3AddSub, rd[4:0], opOpImm};
endfunction

function automatic word_t encLw(int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3Word, rd[4:0], opLoad};
endfunction

function automatic word_t encSw(int rs2, int rs1, int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
endfunction

// runs the program in order, one instruction at a time
function automatic void referenceRun(ref word_t prog[$], ref word_t rdQ[$],
                                     ref word_t valueQ[$], ref int srcQ[$]);
  word_t regs [32];
  word_t mem [dataMemWords];
  word_t w;
  word_t a;
  word_t b;
  word_t res;
  word_t addr;
  logic  wr;
  foreach (regs[i]) regs[i] = '0;
  foreach (mem[i]) mem[i] = '0;
  for (int i = 0; i < prog.size(); i++) begin
    w = prog[i];
    a = regs[w[19:15]];
    b = regs[w[24:20]];
    res = '0;
    wr = 1'b0;
    case (w[6:0])
      opOp: begin
        wr = 1'b1;
        case (w[14:12])
          f3AddSub: res = w[30] ? a - b : a + b;
          f3Slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          f3Sltu: res = (a < b) ? 32'd1 : 32'd0;
          f3Xor: res = a ^ b;
          f3Or: res = a | b;
          default: res = a & b;
        endcase
      end
      opOpImm: begin
        wr = 1'b1;
        res = a + {{20{w[31]}}, w[31:20]};
      end
      opLoad: begin
        wr = 1'b1;
        addr = a + {{20{w[31]}}, w[31:20]};
        res = mem[addr[7:2]];
      end
      opStore: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        mem[addr[7:2]] = b;
      end
      default: ;
    endcase
    // x0 keeps its zero and produces no retire
    if (wr && w[11:7] != 5'd0) begin
      regs[w[11:7]] = res;
      rdQ.push_back(word_t'(w[11:7]));
      valueQ.push_back(res);
      srcQ.push_back(i);
    end
  end
endfunction

`endif

// File: test/rvPipelineTb.sv
`timescale 1ns/1ps

module rvPipelineTb
  import rvIsaPkg::*;
  import rvPipePkg::*;
();

  logic        clk;
  logic        arstN = 1'b1;
  word_t       pc;
  word_t       instruction = nopInstruction;
  logic        retireValid;
  retire_t     retire;

  word_t       progWords[$];
  string       progTest[$];
  int          progLen = 0;
  word_t       expRd[$];
  word_t       expValue[$];
  int          expSrc[$];
  logic [15:0] lfsrState = 16'd22481;
  logic        running = 1'b0;
  int          retired = 0;
  int          cycles = 0;
  int          cycleLimit = 1000;
  word_t       prevPc = '0;
  int          holds = 0;

  `include "rvIsaModel.svh"

  rvPipeline uut (
    .clk(clk),
    .arstN(arstN),
    .pc(pc),
    .instruction(instruction),
    .retireValid(retireValid),
    .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 16 14 13 11
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic int randBits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  task automatic checkEqual(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "wrong value in %s", name);
    end
  endtask

  task automatic failWith(string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic void emit(string name, word_t w);
    progWords.push_back(w);
    progTest.push_back(name);
  endfunction

  function automatic word_t programWord(word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < progLen) begin
      return progWords[idx];
    end
    return nopInstruction;
  endfunction

  // a load whose rd feeds the next instruction holds pc once, two slots later
  function automatic int expectedHolds(word_t atPc);
    int    j;
    word_t ld;
    word_t nx;
    j = int'(atPc >> 2) - 2;
    if (j < 0 || j >= progLen) begin
      return 0;
    end
    ld = progWords[j];
    nx = (j + 1 < progLen) ? progWords[j + 1] : nopInstruction;
    if (ld[6:0] != opLoad || ld[11:7] == 5'd0) begin
      return 0;
    end
    if (nx[19:15] == ld[11:7]) begin
      return 1;
    end
    if ((nx[6:0] == opOp || nx[6:0] == opStore) && nx[24:20] == ld[11:7]) begin
      return 1;
    end
    return 0;
  endfunction

  task automatic buildProgram();
    int kind;
    int rd;
    int rs1;
    int rs2;
    emit("forwarding", encAddi(1, 0, 5));
    emit("forwarding", encAddi(2, 1, -12));
    emit("forwarding", encAlu(0, 3, 1, 2));
    emit("forwarding", encAlu(1, 4, 3, 1));
    emit("forwarding", encAlu(2, 5, 4, 3));
    emit("forwarding", encAlu(3, 6, 5, 2));
    emit("forwarding", encAlu(4, 7, 6, 4));
    emit("forwarding", encAlu(5, 8, 4, 1));
    emit("forwarding", encAlu(6, 9, 4, 1));
    emit("forwarding", encAddi(10, 0, -2048));
    emit("forwarding", encAddi(10, 10, 2047));
    emit("loadUse", encSw(2, 0, 8));
    emit("loadUse", encLw(11, 0, 8));
    emit("loadUse", encAlu(0, 12, 11, 1));
    emit("loadUse", encLw(13, 0, 8));
    emit("loadUse", encSw(13, 0, 12));
    emit("loadUse", encLw(14, 0, 12));
    emit("loadUse", encAddi(14, 14, 1));
    emit("memory", encSw(7, 0, 0));
    emit("memory", encSw(3, 0, 252));
    emit("memory", encLw(15, 0, 0));
    emit("memory", encLw(16, 0, 252));
    // never written
    emit("memory", encLw(17, 0, 100));
    emit("memory", encSw(1, 0, 0));
    emit("memory", encLw(18, 0, 0));
    emit("x0", encAddi(0, 0, 77));
    emit("x0", encAlu(0, 0, 1, 2));
    emit("x0", encLw(0, 0, 8));
    emit("x0", encAlu(0, 19, 0, 1));
    emit("x0", encAddi(20, 0, 0));
    emit("x0", encAlu(6, 21, 0, 1));
    // small register window so dependencies are dense
    for (int k = 0; k < 200; k++) begin
      kind = randBits(4);
      rd = randBits(3);
      rs1 = randBits(3);
      rs2 = randBits(3);
      if (kind < 7) begin
        emit("random", encAlu(kind, rd, rs1, rs2));
      end else if (kind < 11) begin
        emit("random", encAddi(rd, rs1, randBits(12)));
      end else if (kind < 13) begin
        emit("random", encLw(rd, 0, randBits(6) * 4));
      end else begin
        emit("random", encSw(rs2, 0, randBits(6) * 4));
      end
    end
  endtask

  // instruction memory answers the current pc
  always @(pc or progLen) begin
    instruction <= programWord(pc);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      failWith($sformatf("timeout after %0d cycles, %0d of %0d writes retired",
                         cycles, retired, expRd.size()));
    end
  end

  always @(negedge clk) begin
    if (running) begin
      if (retireValid) begin
        if (retired >= expRd.size()) begin
          failWith("a register write retired after the last expected one");
        end else begin
          checkEqual({progTest[expSrc[retired]], " rd"}, expRd[retired], word_t'(retire.rd));
          checkEqual({progTest[expSrc[retired]], " value"}, expValue[retired], retire.value);
          retired = retired + 1;
        end
      end
      if (pc == prevPc) begin
        holds = holds + 1;
      end else begin
        checkEqual("loadUse pc hold", word_t'(expectedHolds(prevPc)), word_t'(holds));
        checkEqual("pc step", prevPc + 32'd4, pc);
        holds = 0;
      end
      prevPc = pc;
    end
  end

  initial begin
    arstN <= 1'b0;
    buildProgram();
    progLen = progWords.size();
    referenceRun(progWords, expRd, expValue, expSrc);
    cycleLimit = 2 * progLen + 40;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) begin
        arstN <= 1'b1;
      end
      @(negedge clk);
      checkEqual("reset pc", '0, pc);
      checkEqual("reset retireValid", '0, word_t'(retireValid));
    end
    @(posedge clk);
    running <= 1'b1;
    wait (retired == expRd.size());
    // stray retires after the last one still fail
    repeat (10) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: rvPipeline.f
+incdir+test
rtl/rvIsaPkg.sv
rtl/rvPipePkg.sv
rtl/fetchUnit.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/rvPipeline.sv
test/rvPipelineTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvPipelineTb
FILELIST  ?= rvPipeline.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
